//--- Makefile
SRCS := $(filter %.sv %.v,$(shell cat build.f))

.PHONY: run clean

run: obj_dir/Valu_tb
	@out="$$(./obj_dir/Valu_tb)"; echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

obj_dir/Valu_tb: build.f $(SRCS) include/alu_tb_vectors.svh
	verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f build.f

clean:
	rm -rf obj_dir

//--- build.f
+incdir+include
hdl/alu_pkg.sv
hdl/alu_issue.sv
hdl/barrel_shifter.sv
hdl/add_logic_unit.sv
hdl/alu_result.sv
hdl/alu_top.sv
dv/alu_tb.sv

//--- include/alu_tb_vectors.svh
`ifndef ALU_TB_VECTORS_SVH
`define ALU_TB_VECTORS_SVH

// columns: idle cycle before the entry, op, a, b, expected result, zero, overflow
task automatic load_directed_vectors();
   // shifts on an operand with the MSB set and one with it clear
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h8765_4321, 32'h0000_0001, 32'h0eca_8642, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h8765_4321, 32'h0000_000f, 32'ha190_8000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h8765_4321, 32'h0000_0010, 32'h4321_0000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h8765_4321, 32'h0000_001f, 32'h8000_0000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h1234_5678, 32'h0000_0001, 32'h2468_acf0, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h1234_5678, 32'h0000_000f, 32'h2b3c_0000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h1234_5678, 32'h0000_0010, 32'h5678_0000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h1234_5678, 32'h0000_001f, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b1, alu_pkg::OP_SRL,  32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h8765_4321, 32'h0000_0001, 32'h43b2_a190, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h8765_4321, 32'h0000_000f, 32'h0001_0eca, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h8765_4321, 32'h0000_0010, 32'h0000_8765, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h8765_4321, 32'h0000_001f, 32'h0000_0001, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h1234_5678, 32'h0000_0001, 32'h091a_2b3c, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h1234_5678, 32'h0000_000f, 32'h0000_2468, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h1234_5678, 32'h0000_0010, 32'h0000_1234, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h1234_5678, 32'h0000_001f, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h8765_4321, 32'h0000_0001, 32'hc3b2_a190, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h8765_4321, 32'h0000_000f, 32'hffff_0eca, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h8765_4321, 32'h0000_0010, 32'hffff_8765, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h8765_4321, 32'h0000_001f, 32'hffff_ffff, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h1234_5678, 32'h0000_0000, 32'h1234_5678, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h1234_5678, 32'h0000_0001, 32'h091a_2b3c, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h1234_5678, 32'h0000_000f, 32'h0000_2468, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h1234_5678, 32'h0000_0010, 32'h0000_1234, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h1234_5678, 32'h0000_001f, 32'h0000_0000, 1'b1, 1'b0);
   // upper bits of b must not change the shift amount
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h8765_4321, 32'h0000_0121, 32'h0eca_8642, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h8765_4321, 32'hffff_fff0, 32'hffff_8765, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SRL,  32'h8765_4321, 32'h0000_0020, 32'h8765_4321, 1'b0, 1'b0);
   // signed boundaries of the adder
   add_vector(1'b1, alu_pkg::OP_ADD,  32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b0, 1'b1);
   add_vector(1'b0, alu_pkg::OP_SUB,  32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff, 1'b0, 1'b1);
   add_vector(1'b0, alu_pkg::OP_ADD,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_ADD,  32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 1'b1, 1'b1);
   add_vector(1'b0, alu_pkg::OP_ADD,  32'h7fff_ffff, 32'h7fff_ffff, 32'hffff_fffe, 1'b0, 1'b1);
   add_vector(1'b0, alu_pkg::OP_ADD,  32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 1'b0, 1'b1);
   add_vector(1'b0, alu_pkg::OP_SUB,  32'h7fff_ffff, 32'hffff_ffff, 32'h8000_0000, 1'b0, 1'b1);
   add_vector(1'b0, alu_pkg::OP_SUB,  32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 1'b0, 1'b1);
   add_vector(1'b0, alu_pkg::OP_SUB,  32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SUB,  32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_ADD,  32'h1234_5678, 32'h1111_1111, 32'h2345_6789, 1'b0, 1'b0);
   add_vector(1'b1, alu_pkg::OP_SUB,  32'h0000_0005, 32'h0000_0005, 32'h0000_0000, 1'b1, 1'b0);
   // signed and unsigned order differ on these operands
   add_vector(1'b0, alu_pkg::OP_SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLT,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLTU, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLT,  32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLTU, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLT,  32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_SLT,  32'h0000_0005, 32'h0000_0005, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_AND,  32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_OR,   32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_XOR,  32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_XOR,  32'h8765_4321, 32'h8765_4321, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_AND,  32'h0f0f_0f0f, 32'hf0f0_f0f0, 32'h0000_0000, 1'b1, 1'b0);
   add_vector(1'b0, alu_pkg::OP_OR,   32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0);
   // units alternate every cycle
   add_vector(1'b0, alu_pkg::OP_SRA,  32'h8000_0000, 32'h0000_001f, 32'hffff_ffff, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_ADD,  32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000, 1'b0, 1'b1);
   add_vector(1'b0, alu_pkg::OP_SLL,  32'h0000_0001, 32'h0000_001f, 32'h8000_0000, 1'b0, 1'b0);
   add_vector(1'b0, alu_pkg::OP_XOR,  32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 1'b1, 1'b0);
endtask

`endif

//--- dv/alu_tb.sv
`default_nettype none

module alu_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DATA_WIDTH   = 32;
   localparam int SHIFT_WIDTH  = $clog2(DATA_WIDTH);
   localparam int RESET_CYCLES = 3;
   localparam int NUM_RANDOM   = 200;

   typedef struct packed {
      logic                  idle;
      alu_pkg::op_t          op;
      logic [DATA_WIDTH-1:0] a;
      logic [DATA_WIDTH-1:0] b;
      logic [DATA_WIDTH-1:0] result;
      logic                  zero;
      logic                  overflow;
   } vector_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] result;
      logic                  zero;
      logic                  overflow;
      int                    due;
   } expect_t;

   logic                  clk;
   logic                  rst;
   logic                  in_valid;
   alu_pkg::op_t          op;
   logic [DATA_WIDTH-1:0] a;
   logic [DATA_WIDTH-1:0] b;
   logic                  out_valid;
   logic [DATA_WIDTH-1:0] result;
   logic                  zero;
   logic                  overflow;

   vector_t vectors[$];
   expect_t expected[$]; // results in flight, oldest first
   int      edge_count      = 0;
   int      cycle_limit     = 50;
   int      value_errors    = 0;
   int      protocol_errors = 0;
   int      checked         = 0;

   alu_top #(.DATA_WIDTH(DATA_WIDTH)) u_alu_top (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .op        (op),
      .a         (a),
      .b         (b),
      .out_valid (out_valid),
      .result    (result),
      .zero      (zero),
      .overflow  (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic add_vector(input logic idle, input alu_pkg::op_t op_v,
                             input logic [DATA_WIDTH-1:0] a_v, input logic [DATA_WIDTH-1:0] b_v,
                             input logic [DATA_WIDTH-1:0] res_v, input logic zero_v,
                             input logic ovf_v);
      vector_t v;
      v.idle     = idle;
      v.op       = op_v;
      v.a        = a_v;
      v.b        = b_v;
      v.result   = res_v;
      v.zero     = zero_v;
      v.overflow = ovf_v;
      vectors.push_back(v);
   endtask

   `include "alu_tb_vectors.svh"

   // signed overflow means the true sum no longer fits in DATA_WIDTH bits
   function automatic void reference(input alu_pkg::op_t op_v,
                                     input logic [DATA_WIDTH-1:0] a_v,
                                     input logic [DATA_WIDTH-1:0] b_v,
                                     output logic [DATA_WIDTH-1:0] res,
                                     output logic ovf);
      longint wide;
      res  = '0;
      ovf  = 1'b0;
      wide = 0;
      case (op_v)
         alu_pkg::OP_ADD: begin
            res  = a_v + b_v;
            wide = longint'($signed(a_v)) + longint'($signed(b_v));
            ovf  = (wide != longint'($signed(res)));
         end
         alu_pkg::OP_SUB: begin
            res  = a_v - b_v;
            wide = longint'($signed(a_v)) - longint'($signed(b_v));
            ovf  = (wide != longint'($signed(res)));
         end
         alu_pkg::OP_AND:  res = a_v & b_v;
         alu_pkg::OP_OR:   res = a_v | b_v;
         alu_pkg::OP_XOR:  res = a_v ^ b_v;
         alu_pkg::OP_SLL:  res = a_v << b_v[SHIFT_WIDTH-1:0];
         alu_pkg::OP_SRL:  res = a_v >> b_v[SHIFT_WIDTH-1:0];
         alu_pkg::OP_SRA:  res = $signed(a_v) >>> b_v[SHIFT_WIDTH-1:0];
         alu_pkg::OP_SLT:  res = {{(DATA_WIDTH-1){1'b0}}, ($signed(a_v) < $signed(b_v))};
         alu_pkg::OP_SLTU: res = {{(DATA_WIDTH-1){1'b0}}, (a_v < b_v)};
         default:          res = '0;
      endcase
   endfunction

   task automatic add_random_vectors(input int count);
      logic [3:0]            code;
      logic [DATA_WIDTH-1:0] ra;
      logic [DATA_WIDTH-1:0] rb;
      logic [DATA_WIDTH-1:0] res;
      logic                  ovf;
      logic                  idle;
      for (int n = 0; n < count; n++) begin
         code = 4'($urandom_range(9, 0));
         ra   = $urandom();
         rb   = $urandom();
         if ($urandom_range(7, 0) == 0) begin
            rb = ra; // equal operands reach the zero flag through SUB, XOR and compares
         end
         idle = ($urandom_range(3, 0) == 0);
         reference(alu_pkg::op_t'(code), ra, rb, res, ovf);
         add_vector(idle, alu_pkg::op_t'(code), ra, rb, res, (res == '0), ovf);
      end
   endtask

   task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] exp_val,
                             input logic [DATA_WIDTH-1:0] act_val);
      assert (act_val === exp_val) else begin
         $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp_val, act_val);
         value_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp_val, input logic act_val);
      assert (act_val === exp_val) else begin
         $display("Fail time=%0t signal=%s expected=%b actual=%b", $time, name, exp_val, act_val);
         value_errors++;
      end
   endtask

   task automatic check_cycle(input int exp_cycle, input int act_cycle);
      assert (act_cycle == exp_cycle) else begin
         $display("Fail time=%0t signal=out_valid expected=cycle %0d actual=cycle %0d",
                  $time, exp_cycle, act_cycle);
         value_errors++;
      end
   endtask

   always @(posedge clk) begin
      edge_count <= edge_count + 1;
      if (edge_count >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("errors: %0d value, %0d protocol, %0d of %0d results checked",
                  value_errors, protocol_errors, checked, vectors.size());
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // outputs are sampled mid-cycle, well away from the register updates
   always @(negedge clk) begin : output_check
      expect_t item;
      logic    late;
      if (edge_count >= 1 && edge_count <= RESET_CYCLES + 1) begin
         check_bit("out_valid", 1'b0, out_valid);
         check_bit("zero", 1'b0, zero);
         check_bit("overflow", 1'b0, overflow);
         check_word("result", '0, result);
      end
      if (out_valid) begin
         assert (expected.size() != 0) else begin
            $display("Error at %0t: out_valid was high with no operation in flight", $time);
            protocol_errors++;
         end
         if (expected.size() != 0) begin
            item = expected.pop_front();
            checked++;
            check_cycle(item.due, edge_count);
            check_word("result", item.result, result);
            check_bit("zero", item.zero, zero);
            check_bit("overflow", item.overflow, overflow);
         end
      end else if (expected.size() != 0) begin
         late = (expected[0].due <= edge_count);
         assert (!late) else begin
            $display("Error at %0t: the result due in cycle %0d never came out",
                     $time, expected[0].due);
            protocol_errors++;
         end
         if (late) begin
            item = expected.pop_front();
         end
      end
   end

   initial begin : stimulus
      vector_t vec;
      expect_t item;
      $timeformat(-9, 1, " ns", 0);
      void'($urandom(32'h2dda));
      load_directed_vectors();
      add_random_vectors(NUM_RANDOM);
      cycle_limit = 2 * vectors.size() + 50; // each entry takes at most two cycles

      rst      <= 1'b1;
      in_valid <= 1'b0;
      op       <= alu_pkg::OP_ADD;
      a        <= '0;
      b        <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      for (int idx = 0; idx < vectors.size(); idx++) begin
         vec = vectors[idx];
         if (vec.idle) begin
            @(posedge clk);
            in_valid <= 1'b0;
            a        <= ~vec.a; // the issue stage has to ignore this
            b        <= ~vec.b;
         end
         @(posedge clk);
         in_valid <= 1'b1;
         op       <= vec.op;
         a        <= vec.a;
         b        <= vec.b;
         item.result   = vec.result;
         item.zero     = vec.zero;
         item.overflow = vec.overflow;
         // edge_count has not counted this edge yet
         // the issue and result registers then load on the next two edges
         item.due = edge_count + 3;
         expected.push_back(item);
      end
      @(posedge clk);
      in_valid <= 1'b0;

      while (expected.size() != 0) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);

      $display("errors: %0d value, %0d protocol, %0d of %0d results checked",
               value_errors, protocol_errors, checked, vectors.size());
      if (value_errors == 0 && protocol_errors == 0 && checked == vectors.size()) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/add_logic_unit.sv
`default_nettype none

module add_logic_unit #(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   input  alu_pkg::logic_op_t    logic_op,
   output logic [DATA_WIDTH-1:0] result,
   output logic                  overflow
);

   logic                  subtract;
   logic [DATA_WIDTH-1:0] b_op;
   logic [DATA_WIDTH:0]   sum_ext;
   logic [DATA_WIDTH-1:0] sum;
   logic                  carry_out;
   logic                  signed_ovf;
   logic                  less_signed;
   logic                  less_unsigned;

   // compares reuse the adder as a - b
   assign subtract = (logic_op != alu_pkg::LOP_ADD);
   assign b_op     = subtract ? ~b : b;
   assign sum_ext  = {1'b0, a} + {1'b0, b_op} + {{DATA_WIDTH{1'b0}}, subtract};
   assign sum       = sum_ext[DATA_WIDTH-1:0];
   assign carry_out = sum_ext[DATA_WIDTH];

   // operands of equal sign giving a result of the other sign
   assign signed_ovf = (a[DATA_WIDTH-1] == b_op[DATA_WIDTH-1]) &&
                       (sum[DATA_WIDTH-1] != a[DATA_WIDTH-1]);

   assign less_signed   = sum[DATA_WIDTH-1] ^ signed_ovf;
   assign less_unsigned = ~carry_out; // no carry out of a + ~b + 1 means a < b

   always_comb begin
      case (logic_op)
         alu_pkg::LOP_ADD,
         alu_pkg::LOP_SUB:  result = sum;
         alu_pkg::LOP_AND:  result = a & b;
         alu_pkg::LOP_OR:   result = a | b;
         alu_pkg::LOP_XOR:  result = a ^ b;
         alu_pkg::LOP_SLT:  result = {{(DATA_WIDTH-1){1'b0}}, less_signed};
         alu_pkg::LOP_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, less_unsigned};
         default:           result = '0;
      endcase
   end

   assign overflow = signed_ovf &&
                     (logic_op == alu_pkg::LOP_ADD || logic_op == alu_pkg::LOP_SUB);

endmodule

`default_nettype wire

//--- hdl/alu_issue.sv
`default_nettype none

module alu_issue #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   in_valid,
   input  alu_pkg::op_t           op,
   input  logic [DATA_WIDTH-1:0]  a,
   input  logic [DATA_WIDTH-1:0]  b,
   output logic                   iss_valid,
   output logic [DATA_WIDTH-1:0]  iss_a,
   output logic [DATA_WIDTH-1:0]  iss_b,
   output logic                   shift_right,
   output logic                   shift_arith,
   output alu_pkg::logic_op_t     logic_op,
   output alu_pkg::unit_sel_t     unit_sel
);

   logic               dec_right;
   logic               dec_arith;
   alu_pkg::logic_op_t dec_logic_op;
   alu_pkg::unit_sel_t dec_unit_sel;

   // decode here so that neither execution unit needs to know op_t
   always_comb begin
      dec_right    = 1'b0;
      dec_arith    = 1'b0;
      dec_logic_op = alu_pkg::LOP_ADD;
      dec_unit_sel = alu_pkg::UNIT_ARITH;
      case (op)
         alu_pkg::OP_ADD:  dec_logic_op = alu_pkg::LOP_ADD;
         alu_pkg::OP_SUB:  dec_logic_op = alu_pkg::LOP_SUB;
         alu_pkg::OP_AND:  dec_logic_op = alu_pkg::LOP_AND;
         alu_pkg::OP_OR:   dec_logic_op = alu_pkg::LOP_OR;
         alu_pkg::OP_XOR:  dec_logic_op = alu_pkg::LOP_XOR;
         alu_pkg::OP_SLT:  dec_logic_op = alu_pkg::LOP_SLT;
         alu_pkg::OP_SLTU: dec_logic_op = alu_pkg::LOP_SLTU;
         alu_pkg::OP_SLL: begin
            dec_unit_sel = alu_pkg::UNIT_SHIFT;
         end
         alu_pkg::OP_SRL: begin
            dec_unit_sel = alu_pkg::UNIT_SHIFT;
            dec_right    = 1'b1;
         end
         alu_pkg::OP_SRA: begin
            dec_unit_sel = alu_pkg::UNIT_SHIFT;
            dec_right    = 1'b1;
            dec_arith    = 1'b1; // only SRA fills with the sign bit
         end
         default: begin
            dec_unit_sel = alu_pkg::UNIT_ARITH;
            dec_logic_op = alu_pkg::LOP_ADD;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         iss_valid <= 1'b0;
      end else begin
         iss_valid <= in_valid;
      end
   end

   // operands and controls only move when a new operation arrives
   always_ff @(posedge clk) begin
      if (in_valid) begin
         iss_a       <= a;
         iss_b       <= b;
         shift_right <= dec_right;
         shift_arith <= dec_arith;
         logic_op    <= dec_logic_op;
         unit_sel    <= dec_unit_sel;
      end
   end

endmodule

`default_nettype wire

//--- hdl/alu_pkg.sv
`default_nettype none

package alu_pkg;

   // operations accepted at the ALU input
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_SRL  = 4'd6,
      OP_SRA  = 4'd7,
      OP_SLT  = 4'd8,
      OP_SLTU = 4'd9
   } op_t;

   typedef enum logic {
      UNIT_SHIFT = 1'b0,
      UNIT_ARITH = 1'b1
   } unit_sel_t;

   // functions of the add/logic unit, decoded once in the issue stage
   typedef enum logic [2:0] {
      LOP_ADD  = 3'd0,
      LOP_SUB  = 3'd1,
      LOP_AND  = 3'd2,
      LOP_OR   = 3'd3,
      LOP_XOR  = 3'd4,
      LOP_SLT  = 3'd5,
      LOP_SLTU = 3'd6
   } logic_op_t;

endpackage

`default_nettype wire

//--- hdl/alu_result.sv
`default_nettype none

module alu_result #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  iss_valid,
   input  alu_pkg::unit_sel_t    unit_sel,
   input  logic [DATA_WIDTH-1:0] shift_result,
   input  logic [DATA_WIDTH-1:0] arith_result,
   input  logic                  arith_overflow,
   output logic                  out_valid,
   output logic [DATA_WIDTH-1:0] result,
   output logic                  zero,
   output logic                  overflow
);

   logic [DATA_WIDTH-1:0] sel_result;
   logic                  sel_overflow;

   assign sel_result = (unit_sel == alu_pkg::UNIT_SHIFT) ? shift_result : arith_result;

   // shifts never report overflow
   assign sel_overflow = (unit_sel == alu_pkg::UNIT_ARITH) && arith_overflow;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
         result    <= '0;
         zero      <= 1'b0;
         overflow  <= 1'b0;
      end else begin
         out_valid <= iss_valid;
         if (iss_valid) begin
            result   <= sel_result;
            zero     <= (sel_result == '0);
            overflow <= sel_overflow;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/alu_top.sv
`default_nettype none

module alu_top #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  in_valid,
   input  alu_pkg::op_t          op,
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   output logic                  out_valid,
   output logic [DATA_WIDTH-1:0] result,
   output logic                  zero,
   output logic                  overflow
);

   localparam int SHIFT_WIDTH = $clog2(DATA_WIDTH);

   logic                  iss_valid;
   logic [DATA_WIDTH-1:0] iss_a;
   logic [DATA_WIDTH-1:0] iss_b;
   logic                  shift_right;
   logic                  shift_arith;
   alu_pkg::logic_op_t    logic_op;
   alu_pkg::unit_sel_t    unit_sel;
   logic [DATA_WIDTH-1:0] shift_result;
   logic [DATA_WIDTH-1:0] arith_result;
   logic                  arith_overflow;

   alu_issue #(.DATA_WIDTH(DATA_WIDTH)) u_alu_issue (
      .clk         (clk),
      .rst         (rst),
      .in_valid    (in_valid),
      .op          (op),
      .a           (a),
      .b           (b),
      .iss_valid   (iss_valid),
      .iss_a       (iss_a),
      .iss_b       (iss_b),
      .shift_right (shift_right),
      .shift_arith (shift_arith),
      .logic_op    (logic_op),
      .unit_sel    (unit_sel)
   );

   // shift amount is the low bits of b
   barrel_shifter #(.DATA_WIDTH(DATA_WIDTH)) u_barrel_shifter (
      .d_in        (iss_a),
      .shift       (iss_b[SHIFT_WIDTH-1:0]),
      .shift_right (shift_right),
      .shift_arith (shift_arith),
      .d_out       (shift_result)
   );

   add_logic_unit #(.DATA_WIDTH(DATA_WIDTH)) u_add_logic_unit (
      .a        (iss_a),
      .b        (iss_b),
      .logic_op (logic_op),
      .result   (arith_result),
      .overflow (arith_overflow)
   );

   alu_result #(.DATA_WIDTH(DATA_WIDTH)) u_alu_result (
      .clk            (clk),
      .rst            (rst),
      .iss_valid      (iss_valid),
      .unit_sel       (unit_sel),
      .shift_result   (shift_result),
      .arith_result   (arith_result),
      .arith_overflow (arith_overflow),
      .out_valid      (out_valid),
      .result         (result),
      .zero           (zero),
      .overflow       (overflow)
   );

endmodule

`default_nettype wire

//--- hdl/barrel_shifter.sv
`default_nettype none

module barrel_shifter #(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0]         d_in,
   input  logic [$clog2(DATA_WIDTH)-1:0] shift,
   input  logic                          shift_right,
   input  logic                          shift_arith,
   output logic [DATA_WIDTH-1:0]         d_out
);

   localparam int SHIFT_WIDTH = $clog2(DATA_WIDTH);

   logic                  msb_fill;
   logic [DATA_WIDTH-1:0] d_in_rev;
   logic [DATA_WIDTH-1:0] array_out_rev;

   // column k holds the data after the shifts selected by shift[k-1:0]
   logic [DATA_WIDTH-1:0] column [SHIFT_WIDTH+1];

   assign msb_fill = shift_arith ? d_in[DATA_WIDTH-1] : 1'b0;

   // the array only shifts right, a left shift runs through it bit-reversed
   for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_reverse
      assign d_in_rev[i]      = d_in[DATA_WIDTH-1-i];
      assign array_out_rev[i] = column[SHIFT_WIDTH][DATA_WIDTH-1-i];
   end

   assign column[0] = shift_right ? d_in : d_in_rev;

   for (genvar k = 0; k < SHIFT_WIDTH; k++) begin : g_column
      localparam int STEP = 2 ** k;

      logic [DATA_WIDTH-1:0] shifted;

      assign shifted = {{STEP{msb_fill}}, column[k][DATA_WIDTH-1:STEP]};
      assign column[k+1] = shift[k] ? shifted : column[k];
   end

   assign d_out = shift_right ? column[SHIFT_WIDTH] : array_out_rev;

endmodule

`default_nettype wire
